/* vlog.f */
+incdir+design
+incdir+test
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_agu.sv
design/ex_mem_reg.sv
design/ex_stage.sv
test/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - design
    files:
      - design/ex_pkg.sv
      - design/ex_alu.sv
      - design/ex_branch.sv
      - design/ex_agu.sv
      - design/ex_mem_reg.sv
      - design/ex_stage.sv
  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/tb_ex_stage.sv

/* test/tb_ex_model.svh */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// everything the stage shows for one request
typedef struct packed {
    logic             valid;
    ex_pkg::wb_t      wb;
    ex_pkg::br_res_t  br;
    ex_pkg::mem_req_t mem;
    ex_pkg::exc_t     exc;
} stage_out_t;

// result class as a decoder would assign it
function automatic ex_pkg::alusel_e class_of(input ex_pkg::aluop_e op);
    if (op == ex_pkg::op_nop) return ex_pkg::res_nop;
    if (op <= ex_pkg::op_nor) return ex_pkg::res_logic;
    if (op <= ex_pkg::op_sra) return ex_pkg::res_shift;
    if (op <= ex_pkg::op_sltu) return ex_pkg::res_arith;
    if (op <= ex_pkg::op_bltzal) return ex_pkg::res_jb;
    return ex_pkg::res_ls;
endfunction

function automatic stage_out_t predict(input logic valid, input ex_pkg::ex_req_t r);
    stage_out_t            o;
    logic [`EX_WORD_W:0]   wide;   // extra bit catches signed overflow
    logic [`EX_WORD_W-1:0] opb;
    logic [`EX_WORD_W-1:0] res;
    logic [`EX_WORD_W-1:0] pc4;
    logic [`EX_WORD_W-1:0] ea;
    ex_pkg::alusel_e       cls;
    o = '0;
    o.br.pred_ok = 1'b1;
    if (!valid) return o;
    o.valid = 1'b1;
    res = '0;
    cls = class_of(r.aluop);
    pc4 = r.pc + 32'd4;
    ea  = r.reg1 + r.imm;
    opb = (r.aluop == ex_pkg::op_addi || r.aluop == ex_pkg::op_addiu) ? r.imm : r.reg2;
    if (cls == ex_pkg::res_jb) o.br.npc = pc4 + r.imm;   // jumps override below
    case (r.aluop)
        ex_pkg::op_or:   res = r.reg1 | r.reg2;
        ex_pkg::op_and:  res = r.reg1 & r.reg2;
        ex_pkg::op_xor:  res = r.reg1 ^ r.reg2;
        ex_pkg::op_nor:  res = ~(r.reg1 | r.reg2);
        ex_pkg::op_sll:  res = r.reg2 << r.reg1[4:0];
        ex_pkg::op_srl:  res = r.reg2 >> r.reg1[4:0];
        ex_pkg::op_sra:  res = $unsigned($signed(r.reg2) >>> r.reg1[4:0]);
        ex_pkg::op_add, ex_pkg::op_addi: begin
            wide = {r.reg1[31], r.reg1} + {opb[31], opb};
            res = wide[31:0];
            o.exc.ov = wide[32] ^ wide[31];
        end
        ex_pkg::op_sub: begin
            wide = {r.reg1[31], r.reg1} - {opb[31], opb};
            res = wide[31:0];
            o.exc.ov = wide[32] ^ wide[31];
        end
        ex_pkg::op_addu, ex_pkg::op_addiu: res = r.reg1 + opb;
        ex_pkg::op_subu: res = r.reg1 - r.reg2;
        ex_pkg::op_slt:  res = ($signed(r.reg1) < $signed(r.reg2)) ? 1 : 0;
        ex_pkg::op_sltu: res = (r.reg1 < r.reg2) ? 1 : 0;
        ex_pkg::op_j, ex_pkg::op_jal: begin
            o.br.taken = 1'b1;
            o.br.npc   = {pc4[31:28], r.imm[27:0]};
            o.br.btype = ex_pkg::btype_cal;
            if (r.aluop == ex_pkg::op_jal) o.br.link = r.pc + 32'd8;
        end
        ex_pkg::op_jr: begin
            o.br.taken = 1'b1;
            o.br.npc   = r.reg1;
            o.br.btype = ex_pkg::btype_ret;
        end
        ex_pkg::op_jalr: begin
            o.br.taken = 1'b1;
            o.br.npc   = r.reg1;
            o.br.btype = ex_pkg::btype_cal;
            o.br.link  = r.pc + 32'd8;
        end
        ex_pkg::op_beq:  o.br.taken = (r.reg1 == r.reg2);
        ex_pkg::op_bne:  o.br.taken = (r.reg1 != r.reg2);
        ex_pkg::op_bgtz: o.br.taken = ($signed(r.reg1) > 0);
        ex_pkg::op_blez: o.br.taken = ($signed(r.reg1) <= 0);
        ex_pkg::op_bgez: o.br.taken = ($signed(r.reg1) >= 0);
        ex_pkg::op_bltz: o.br.taken = ($signed(r.reg1) < 0);
        ex_pkg::op_bgezal, ex_pkg::op_bltzal: begin
            o.br.taken = (r.aluop == ex_pkg::op_bgezal) ? ($signed(r.reg1) >= 0)
                                                        : ($signed(r.reg1) < 0);
            o.br.btype = ex_pkg::btype_cal;
            o.br.link  = r.pc + 32'd8;
        end
        ex_pkg::op_lb, ex_pkg::op_lbu: begin
            o.mem.re  = 1'b1;
            o.mem.sel = 4'b0001 << ea[1:0];
        end
        ex_pkg::op_lh, ex_pkg::op_lhu: begin
            o.mem.re  = 1'b1;
            o.mem.sel = ea[0] ? 4'b0000 : (4'b0011 << ea[1:0]);
            o.exc.adel = ea[0];
        end
        ex_pkg::op_lw: begin
            o.mem.re  = 1'b1;
            o.mem.sel = 4'b1111;
            o.exc.adel = (ea[1:0] != 2'b00);
        end
        ex_pkg::op_sb: begin
            o.mem.we    = 1'b1;
            o.mem.sel   = 4'b0001 << ea[1:0];
            o.mem.wdata = {4{r.reg2[7:0]}};
        end
        ex_pkg::op_sh: begin
            o.mem.we    = 1'b1;
            o.mem.sel   = ea[0] ? 4'b0000 : (4'b0011 << ea[1:0]);
            o.mem.wdata = {2{r.reg2[15:0]}};
            o.exc.ades  = ea[0];
        end
        ex_pkg::op_sw: begin
            o.mem.we    = 1'b1;
            o.mem.sel   = 4'b1111;
            o.mem.wdata = r.reg2;
            o.exc.ades  = (ea[1:0] != 2'b00);
        end
        default: ;
    endcase
    if (cls == ex_pkg::res_jb) begin
        o.br.pred_ok = (r.pred_dir && o.br.taken && r.pred_tar == o.br.npc) ||
                       (!r.pred_dir && !o.br.taken);
    end
    if (cls == ex_pkg::res_ls) o.mem.addr = ea;
    if (o.exc.adel || o.exc.ades) begin
        o.mem.re = 1'b0;   // misaligned, no strobe
        o.mem.we = 1'b0;
    end
    o.wb.waddr = r.waddr;
    o.wb.we    = r.we && !o.exc.ov;
    if (cls == ex_pkg::res_logic || cls == ex_pkg::res_shift || cls == ex_pkg::res_arith) begin
        o.wb.wdata = res;
    end else if (cls == ex_pkg::res_jb) begin
        o.wb.wdata = o.br.link;
    end
    return o;
endfunction

`endif

/* test/tb_ex_stage.sv */
`include "ex_settings.svh"

module tb_ex_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_SLOTS    = 2000;
    localparam int MAX_CYCLES = N_SLOTS + (N_SLOTS * 3) / 10;   // reset plus margin

    logic             clk_i = 1'b0;
    logic             arst_n_i;
    logic             valid_i;
    ex_pkg::ex_req_t  req_i;
    logic             valid_o;
    ex_pkg::wb_t      wb_o;
    ex_pkg::br_res_t  br_o;
    ex_pkg::mem_req_t mem_o;
    ex_pkg::exc_t     exc_o;

    int unsigned lcg_state = 32'd76404;
    int          n_checks  = 0;
    int          n_errors  = 0;
    int          cycles    = 0;

    `include "tb_ex_model.svh"

    stage_out_t pending[$];

    ex_stage ex_stage_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .req_i    (req_i),
        .valid_o  (valid_o),
        .wb_o     (wb_o),
        .br_o     (br_o),
        .mem_o    (mem_o),
        .exc_o    (exc_o)
    );

    always #10 clk_i = ~clk_i;

    // upper half only, the low LCG bits repeat too soon
    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        hi = rand16();
        return {hi, rand16()};
    endfunction

    function automatic ex_pkg::ex_req_t make_req();
        ex_pkg::ex_req_t r;
        stage_out_t      e;
        logic [15:0]     pick;
        pick     = rand16();
        r.aluop  = ex_pkg::aluop_e'(rand16() % 36);
        r.alusel = class_of(r.aluop);
        r.reg1   = rand32();
        r.reg2   = rand32();
        r.imm    = rand32();
        r.pc     = rand32() & ~32'h3;
        r.waddr  = pick[4:0];
        r.we     = pick[5];
        r.pred_dir = pick[6];
        r.pred_tar = rand32();
        case (pick[15:12])
            4'd0: r.reg1 = '0;                       // zero for bgtz/blez
            4'd1: r.reg2 = r.reg1;                   // equal operands
            4'd2, 4'd3: begin
                r.reg1[1:0] = 2'b00;                 // aligned access
                r.imm[1:0]  = 2'b00;
            end
            4'd4: r.imm = {{16{pick[11]}}, rand16()};
            default: ;
        endcase
        e = predict(1'b1, r);
        if (pick[7]) r.pred_tar = e.br.npc;   // target right, so pred_ok hinges on direction
        return r;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
        n_errors++;
    endtask

    task automatic check_outputs(input stage_out_t e);
        n_checks++;
        if (valid_o !== e.valid) report_mismatch("valid_o", valid_o, e.valid);
        if (wb_o !== e.wb) report_mismatch("wb_o", wb_o, e.wb);
        if (br_o !== e.br) report_mismatch("br_o", br_o, e.br);
        if (mem_o !== e.mem) report_mismatch("mem_o", mem_o, e.mem);
        if (exc_o !== e.exc) report_mismatch("exc_o", exc_o, e.exc);
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        ex_pkg::ex_req_t r;
        logic            v;
        arst_n_i = 1'b0;
        valid_i  = 1'b0;
        req_i    = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_outputs(predict(1'b0, req_i));   // held in reset
        arst_n_i = 1'b1;
        // one extra idle slot flushes the last request
        for (int slot = 0; slot <= N_SLOTS; slot++) begin
            if (slot < N_SLOTS) begin
                v = (rand16() % 10) < 8;
                r = make_req();
            end else begin
                v = 1'b0;
                r = '0;
            end
            valid_i = v;
            req_i   = r;
            pending.push_back(predict(v, r));
            #1;   // new request applied, outputs must still hold the previous one
            if (pending.size() > 1) check_outputs(pending.pop_front());
            @(negedge clk_i);
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* design/ex_stage.sv */
module ex_stage (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  ex_pkg::ex_req_t   req_i,
    output logic              valid_o,
    output ex_pkg::wb_t       wb_o,
    output ex_pkg::br_res_t   br_o,
    output ex_pkg::mem_req_t  mem_o,
    output ex_pkg::exc_t      exc_o
);

    logic [$bits(req_i.reg1)-1:0] alu_res;
    logic                         alu_ov;
    ex_pkg::br_res_t              br;
    ex_pkg::mem_req_t             mem;
    logic                         adel;
    logic                         ades;

    ex_alu u_alu (
        .req_i     (req_i),
        .alu_res_o (alu_res),
        .ov_o      (alu_ov)
    );

    ex_branch u_branch (
        .req_i (req_i),
        .br_o  (br)
    );

    ex_agu u_agu (
        .req_i  (req_i),
        .mem_o  (mem),
        .adel_o (adel),
        .ades_o (ades)
    );

    ex_mem_reg u_mem_reg (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .req_i     (req_i),
        .alu_res_i (alu_res),
        .ov_i      (alu_ov),
        .br_i      (br),
        .mem_i     (mem),
        .adel_i    (adel),
        .ades_i    (ades),
        .valid_o   (valid_o),
        .wb_o      (wb_o),
        .br_o      (br_o),
        .mem_o     (mem_o),
        .exc_o     (exc_o)
    );

endmodule

/* design/ex_mem_reg.sv */
`include "ex_settings.svh"

module ex_mem_reg (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  ex_pkg::ex_req_t       req_i,
    input  logic [`EX_WORD_W-1:0] alu_res_i,
    input  logic                  ov_i,
    input  ex_pkg::br_res_t       br_i,
    input  ex_pkg::mem_req_t      mem_i,
    input  logic                  adel_i,
    input  logic                  ades_i,
    output logic                  valid_o,
    output ex_pkg::wb_t           wb_o,
    output ex_pkg::br_res_t       br_o,
    output ex_pkg::mem_req_t      mem_o,
    output ex_pkg::exc_t          exc_o
);

    // no branch in flight means nothing to mispredict
    localparam ex_pkg::br_res_t BR_IDLE = '{
        taken:   1'b0,
        npc:     '0,
        pred_ok: 1'b1,
        btype:   ex_pkg::btype_nul,
        link:    '0
    };

    logic [`EX_WORD_W-1:0] wdata;
    logic                  addr_exc;
    ex_pkg::wb_t           wb_d;
    ex_pkg::mem_req_t      mem_d;
    ex_pkg::exc_t          exc_d;

    always_comb begin
        case (req_i.alusel)
            ex_pkg::res_logic, ex_pkg::res_shift, ex_pkg::res_arith: wdata = alu_res_i;
            ex_pkg::res_jb: wdata = br_i.link;
            default:        wdata = '0;   // ls and nop
        endcase
    end

    assign addr_exc = adel_i | ades_i;

    always_comb begin
        wb_d.waddr = req_i.waddr;
        wb_d.we    = req_i.we & ~ov_i;     // overflow cancels the write
        wb_d.wdata = wdata;
        mem_d      = mem_i;
        mem_d.re   = mem_i.re & ~addr_exc;
        mem_d.we   = mem_i.we & ~addr_exc;
        exc_d.ov   = ov_i;
        exc_d.adel = adel_i;
        exc_d.ades = ades_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            wb_o    <= '0;
            br_o    <= BR_IDLE;
            mem_o   <= '0;
            exc_o   <= '0;
        end else begin
            valid_o <= valid_i;
            wb_o    <= valid_i ? wb_d : '0;
            br_o    <= valid_i ? br_i : BR_IDLE;
            mem_o   <= valid_i ? mem_d : '0;
            exc_o   <= valid_i ? exc_d : '0;
        end
    end

endmodule

/* design/ex_agu.sv */
`include "ex_settings.svh"

module ex_agu (
    input  ex_pkg::ex_req_t   req_i,
    output ex_pkg::mem_req_t  mem_o,
    output logic              adel_o,
    output logic              ades_o
);

    logic [`EX_WORD_W-1:0] ea;
    logic                  is_ls;
    logic [`EX_SEL_W-1:0]  byte_sel;
    logic [`EX_SEL_W-1:0]  half_sel;

    assign ea = req_i.reg1 + req_i.imm;

    // one lane per byte, little endian
    assign byte_sel = 4'b0001 << ea[1:0];
    assign half_sel = ea[0] ? 4'b0000 : (ea[1] ? 4'b1100 : 4'b0011);

    always_comb begin
        mem_o  = '0;
        adel_o = 1'b0;
        ades_o = 1'b0;
        is_ls  = 1'b1;
        case (req_i.aluop)
            ex_pkg::op_lb, ex_pkg::op_lbu: begin
                mem_o.re  = 1'b1;
                mem_o.sel = byte_sel;
            end
            ex_pkg::op_lh, ex_pkg::op_lhu: begin
                mem_o.re  = 1'b1;
                mem_o.sel = half_sel;
                adel_o    = ea[0];
            end
            ex_pkg::op_lw: begin
                mem_o.re  = 1'b1;
                mem_o.sel = '1;
                adel_o    = |ea[1:0];
            end
            ex_pkg::op_sb: begin
                mem_o.we    = 1'b1;
                mem_o.sel   = byte_sel;
                mem_o.wdata = {4{req_i.reg2[7:0]}};
            end
            ex_pkg::op_sh: begin
                mem_o.we    = 1'b1;
                mem_o.sel   = half_sel;
                mem_o.wdata = {2{req_i.reg2[15:0]}};
                ades_o      = ea[0];
            end
            ex_pkg::op_sw: begin
                mem_o.we    = 1'b1;
                mem_o.sel   = '1;
                mem_o.wdata = req_i.reg2;
                ades_o      = |ea[1:0];
            end
            default: is_ls = 1'b0;
        endcase
        mem_o.addr = is_ls ? ea : '0;
    end

endmodule

/* design/ex_branch.sv */
`include "ex_settings.svh"

module ex_branch (
    input  ex_pkg::ex_req_t  req_i,
    output ex_pkg::br_res_t  br_o
);

    localparam int MSB = `EX_WORD_W - 1;

    logic [`EX_WORD_W-1:0] pc_4;
    logic [`EX_WORD_W-1:0] pc_8;
    logic [`EX_WORD_W-1:0] br_tar;
    logic [`EX_WORD_W-1:0] j_tar;
    logic                  is_jb;
    logic                  is_link;
    logic                  taken;
    logic [`EX_WORD_W-1:0] npc;
    ex_pkg::btype_e        btype;

    assign pc_4   = req_i.pc + `EX_PC_STEP;
    assign pc_8   = req_i.pc + `EX_LINK_STEP;
    assign br_tar = pc_4 + req_i.imm;   // imm holds the shifted offset
    assign j_tar  = {pc_4[MSB:`EX_JTARGET_W], req_i.imm[`EX_JTARGET_W-1:0]};

    always_comb begin
        is_jb   = 1'b1;
        is_link = 1'b0;
        taken   = 1'b0;
        npc     = br_tar;
        btype   = ex_pkg::btype_nul;
        case (req_i.aluop)
            ex_pkg::op_j, ex_pkg::op_jal: begin
                taken   = 1'b1;
                npc     = j_tar;
                btype   = ex_pkg::btype_cal;
                is_link = (req_i.aluop == ex_pkg::op_jal);
            end
            ex_pkg::op_jr: begin
                taken = 1'b1;
                npc   = req_i.reg1;
                btype = ex_pkg::btype_ret;
            end
            ex_pkg::op_jalr: begin
                taken   = 1'b1;
                npc     = req_i.reg1;
                btype   = ex_pkg::btype_cal;
                is_link = 1'b1;
            end
            ex_pkg::op_beq:  taken = (req_i.reg1 == req_i.reg2);
            ex_pkg::op_bne:  taken = (req_i.reg1 != req_i.reg2);
            ex_pkg::op_bgtz: taken = !req_i.reg1[MSB] && (req_i.reg1 != '0);
            ex_pkg::op_blez: taken = req_i.reg1[MSB] || (req_i.reg1 == '0);
            ex_pkg::op_bgez: taken = !req_i.reg1[MSB];
            ex_pkg::op_bltz: taken = req_i.reg1[MSB];
            ex_pkg::op_bgezal, ex_pkg::op_bltzal: begin
                // bit 31 decides both, inverted for bgezal
                taken   = req_i.reg1[MSB] ^ (req_i.aluop == ex_pkg::op_bgezal);
                btype   = ex_pkg::btype_cal;
                is_link = 1'b1;
            end
            default: begin
                is_jb = 1'b0;
                npc   = '0;
            end
        endcase
    end

    always_comb begin
        br_o.taken = taken;
        br_o.npc   = npc;
        br_o.btype = btype;
        br_o.link  = is_link ? pc_8 : '0;
        if (!is_jb) begin
            br_o.pred_ok = 1'b1;
        end else begin
            br_o.pred_ok = (req_i.pred_dir && taken && (req_i.pred_tar == npc)) ||
                           (!req_i.pred_dir && !taken);
        end
    end

endmodule

/* design/ex_alu.sv */
`include "ex_settings.svh"

module ex_alu (
    input  ex_pkg::ex_req_t       req_i,
    output logic [`EX_WORD_W-1:0] alu_res_o,
    output logic                  ov_o
);

    localparam int MSB = `EX_WORD_W - 1;

    logic                   sub;
    logic                   use_imm;
    logic [`EX_WORD_W-1:0]  opb;
    logic [`EX_WORD_W-1:0]  opb_add;
    logic [`EX_WORD_W-1:0]  sum;
    logic                   opb_sign;
    logic                   ov_sum;
    logic                   slt_res;
    logic [`EX_SHAMT_W-1:0] shamt;

    assign sub = (req_i.aluop == ex_pkg::op_sub) || (req_i.aluop == ex_pkg::op_subu) ||
                 (req_i.aluop == ex_pkg::op_slt);
    assign use_imm = (req_i.aluop == ex_pkg::op_addi) || (req_i.aluop == ex_pkg::op_addiu);

    assign opb     = use_imm ? req_i.imm : req_i.reg2;
    assign opb_add = sub ? (~opb + 1'b1) : opb;   // two's complement for subtract
    assign sum     = req_i.reg1 + opb_add;

    // sign of the operand actually added, so that a - (-2^31) still flags
    assign opb_sign = opb[MSB] ^ sub;
    assign ov_sum   = (req_i.reg1[MSB] == opb_sign) && (sum[MSB] != req_i.reg1[MSB]);

    always_comb begin
        if (req_i.reg1[MSB] && !req_i.reg2[MSB]) begin
            slt_res = 1'b1;
        end else if (!req_i.reg1[MSB] && req_i.reg2[MSB]) begin
            slt_res = 1'b0;
        end else begin
            slt_res = sum[MSB];   // same signs, difference can't overflow
        end
    end

    assign shamt = req_i.reg1[`EX_SHAMT_W-1:0];

    always_comb begin
        case (req_i.aluop)
            ex_pkg::op_or:   alu_res_o = req_i.reg1 | req_i.reg2;
            ex_pkg::op_and:  alu_res_o = req_i.reg1 & req_i.reg2;
            ex_pkg::op_xor:  alu_res_o = req_i.reg1 ^ req_i.reg2;
            ex_pkg::op_nor:  alu_res_o = ~(req_i.reg1 | req_i.reg2);
            ex_pkg::op_sll:  alu_res_o = req_i.reg2 << shamt;
            ex_pkg::op_srl:  alu_res_o = req_i.reg2 >> shamt;
            ex_pkg::op_sra:  alu_res_o = $signed(req_i.reg2) >>> shamt;
            ex_pkg::op_add, ex_pkg::op_addu, ex_pkg::op_addi, ex_pkg::op_addiu,
            ex_pkg::op_sub, ex_pkg::op_subu: begin
                alu_res_o = sum;
            end
            ex_pkg::op_slt:  alu_res_o = {{MSB{1'b0}}, slt_res};
            ex_pkg::op_sltu: alu_res_o = {{MSB{1'b0}}, req_i.reg1 < req_i.reg2};
            default:         alu_res_o = '0;
        endcase
    end

    // only the trapping forms report overflow
    assign ov_o = ov_sum && ((req_i.aluop == ex_pkg::op_add) ||
                             (req_i.aluop == ex_pkg::op_addi) ||
                             (req_i.aluop == ex_pkg::op_sub));

endmodule

/* design/ex_pkg.sv */
`include "ex_settings.svh"

package ex_pkg;

    typedef enum logic [5:0] {
        op_nop,
        op_or, op_and, op_xor, op_nor,
        op_sll, op_srl, op_sra,
        op_add, op_addu, op_addi, op_addiu,
        op_sub, op_subu, op_slt, op_sltu,
        op_j, op_jal, op_jr, op_jalr,
        op_beq, op_bne, op_bgtz, op_blez,
        op_bgez, op_bltz, op_bgezal, op_bltzal,
        op_lb, op_lbu, op_lh, op_lhu, op_lw,
        op_sb, op_sh, op_sw
    } aluop_e;

    typedef enum logic [2:0] {
        res_nop,
        res_logic,
        res_shift,
        res_arith,
        res_jb,
        res_ls
    } alusel_e;

    // branch kind as seen by the predictor
    typedef enum logic [1:0] {
        btype_nul = 2'b00,
        btype_cal = 2'b01,
        btype_ret = 2'b10
    } btype_e;

    typedef struct packed {
        aluop_e                    aluop;
        alusel_e                   alusel;
        logic [`EX_WORD_W-1:0]     reg1;
        logic [`EX_WORD_W-1:0]     reg2;
        logic [`EX_WORD_W-1:0]     imm;   // already extended
        logic [`EX_WORD_W-1:0]     pc;
        logic [`EX_REG_ADDR_W-1:0] waddr;
        logic                      we;
        logic                      pred_dir;
        logic [`EX_WORD_W-1:0]     pred_tar;
    } ex_req_t;

    typedef struct packed {
        logic [`EX_REG_ADDR_W-1:0] waddr;
        logic                      we;
        logic [`EX_WORD_W-1:0]     wdata;
    } wb_t;

    typedef struct packed {
        logic                  taken;
        logic [`EX_WORD_W-1:0] npc;
        logic                  pred_ok;
        btype_e                btype;
        logic [`EX_WORD_W-1:0] link;
    } br_res_t;

    typedef struct packed {
        logic [`EX_WORD_W-1:0] addr;
        logic                  re;
        logic                  we;
        logic [`EX_SEL_W-1:0]  sel;
        logic [`EX_WORD_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic ov;
        logic adel;
        logic ades;
    } exc_t;

endpackage

/* design/ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// datapath widths
`define EX_WORD_W      32
`define EX_REG_ADDR_W  5
`define EX_SEL_W       4
`define EX_SHAMT_W     5

// pc offsets
`define EX_PC_STEP     4
`define EX_LINK_STEP   8   // skips the delay slot

// j/jal keep this many low bits of imm
`define EX_JTARGET_W   28

`endif
